// ==== verilog.f ====
+incdir+hw
hw/rv32i_types_pkg.sv
hw/pipe_stage_pkg.sv
hw/ex_mem_reg.sv
hw/mem_stage.sv
hw/dmem_sram.sv
hw/wb_stage.sv
hw/mem_wb_top.sv
sim/mem_checker.sv
sim/mem_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = mem_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/mem_cases.txt ====
# stimulus: opcode funct3 mem_read mem_write rf_sel load_rf pc alu_out mar store_data cmp u_imm rd
# expected commit: we rd_data mem_addr rmask wmask wdata, every column in hex
23 2 0 1 0 0 00000000 00000100 00000100 12345678 0 00000000 00 0 00000100 00000100 0 f 12345678
03 2 1 0 5 1 00000004 00000100 00000100 00000000 0 00000000 05 1 12345678 00000100 f 0 00000000
23 0 0 1 0 0 00000008 00000104 00000104 000000a1 0 00000000 00 0 00000104 00000104 0 1 000000a1
23 0 0 1 0 0 0000000c 00000105 00000105 000000b2 0 00000000 00 0 00000105 00000104 0 2 0000b200
23 0 0 1 0 0 00000010 00000106 00000106 000000c3 0 00000000 00 0 00000106 00000104 0 4 00c30000
23 0 0 1 0 0 00000014 00000107 00000107 000000d4 0 00000000 00 0 00000107 00000104 0 8 d4000000
03 2 1 0 5 1 00000018 00000104 00000104 00000000 0 00000000 06 1 d4c3b2a1 00000104 f 0 00000000
23 2 0 1 0 0 0000001c 00000108 00000108 11223344 0 00000000 00 0 00000108 00000108 0 f 11223344
23 1 0 1 0 0 00000020 0000010a 0000010a 0000cafe 0 00000000 00 0 0000010a 00000108 0 c cafe0000
03 2 1 0 5 1 00000024 00000108 00000108 00000000 0 00000000 07 1 cafe3344 00000108 f 0 00000000
23 1 0 1 0 0 00000028 0000010c 0000010c 00005a5a 0 00000000 00 0 0000010c 0000010c 0 3 00005a5a
03 2 1 0 5 1 0000002c 0000010c 0000010c 00000000 0 00000000 08 1 00005a5a 0000010c f 0 00000000
03 0 1 0 5 1 00000030 00000105 00000105 00000000 0 00000000 09 1 ffffffb2 00000104 2 0 00000000
03 4 1 0 5 1 00000034 00000107 00000107 00000000 0 00000000 0a 1 000000d4 00000104 8 0 00000000
03 1 1 0 5 1 00000038 00000106 00000106 00000000 0 00000000 0b 1 ffffd4c3 00000104 c 0 00000000
03 5 1 0 5 1 0000003c 00000104 00000104 00000000 0 00000000 0c 1 0000b2a1 00000104 3 0 00000000
33 0 0 0 0 1 00000040 0000abcd 00000000 00000000 0 00000000 0d 1 0000abcd 00000000 0 0 00000000
13 2 0 0 1 1 00000044 00000000 00000000 00000000 1 00000000 0e 1 00000001 00000000 0 0 00000000
37 0 0 0 2 1 00000048 00000000 00000000 00000000 0 12345000 0f 1 12345000 00000000 0 0 00000000
6f 0 0 0 4 1 00000200 00000000 00000000 00000000 0 00000000 01 1 00000204 00000000 0 0 00000000
33 0 0 0 0 1 00000204 0000ffff 00000000 00000000 0 00000000 00 0 0000ffff 00000000 0 0 00000000

// ==== sim/mem_tb.sv ====
`default_nettype none

module mem_tb;

    logic                          clk;
    logic                          rst_n;
    pipe_stage_pkg::ex_mem_stage_t ex_in;
    rv32i_types_pkg::rv32i_word    fwd_data;
    pipe_stage_pkg::commit_t       commit;
    logic                          exp_push;
    logic                          fwd_check;
    pipe_stage_pkg::commit_t       exp_commit;
    rv32i_types_pkg::rv32i_word    exp_fwd;
    int                            pass_count;
    int                            fail_count;
    int                            pending;
    int                            fd;
    int                            n;
    int                            n_cases;
    int                            errors;
    int                            gap;
    int                            waited;
    int                            fail_before;
    string                         line;
    // one case line, stimulus then expected
    logic [6:0]                    c_op;
    logic [2:0]                    c_f3, c_sel;
    logic                          c_mrd, c_mwr, c_ldrf, c_cmp, x_we;
    logic [4:0]                    c_rd;
    logic [31:0]                   c_pc, c_alu, c_mar, c_sdata, c_uimm;
    logic [31:0]                   x_data, x_addr, x_wdata;
    logic [3:0]                    x_rmask, x_wmask;

    mem_wb_top mem_wb_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_in    (ex_in),
        .fwd_data (fwd_data),
        .commit   (commit)
    );

    mem_checker mem_checker_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .commit     (commit),
        .fwd_data   (fwd_data),
        .exp_push   (exp_push),
        .exp_commit (exp_commit),
        .fwd_check  (fwd_check),
        .exp_fwd    (exp_fwd),
        .pass_count (pass_count),
        .fail_count (fail_count),
        .pending    (pending)
    );

    always #4 clk = ~clk;

    // bubble for one cycle
    task automatic idle_cycle;
        @(posedge clk);
        #1;
        ex_in.ctrl_wd.valid = 1'b0;
        exp_push            = 1'b0;
    endtask

    // one valid item from the current case line
    task automatic drive_case;
        @(posedge clk);
        #1;
        ex_in.ctrl_wd.valid          = 1'b1;
        ex_in.ctrl_wd.opcode         = rv32i_types_pkg::opcode_t'(c_op);
        ex_in.ctrl_wd.funct3         = c_f3;
        ex_in.ctrl_wd.mem_read       = c_mrd;
        ex_in.ctrl_wd.mem_write      = c_mwr;
        ex_in.ctrl_wd.regfilemux_sel = rv32i_types_pkg::regfilemux_sel_t'(c_sel);
        ex_in.ctrl_wd.load_regfile   = c_ldrf;
        ex_in.ctrl_wd.pc             = c_pc;
        ex_in.alu_out                = c_alu;
        ex_in.mar                    = c_mar;
        ex_in.mem_data_out           = c_sdata;
        ex_in.cmp_out                = c_cmp;
        ex_in.u_imm                  = c_uimm;
        ex_in.rd                     = c_rd;
        exp_commit.valid             = 1'b1;
        exp_commit.we                = x_we;
        exp_commit.rd                = c_rd;
        exp_commit.rd_data           = x_data;
        exp_commit.mem_addr          = x_addr;
        exp_commit.mem_rmask         = x_rmask;
        exp_commit.mem_wmask         = x_wmask;
        exp_commit.mem_wdata         = x_wdata;
        // non-load regfile value is the forwarded value too
        exp_fwd                      = x_data;
        fwd_check                    = (c_op != rv32i_types_pkg::op_load);
        exp_push                     = 1'b1;
    endtask

    initial begin
        void'($urandom(91996));
        clk        = 1'b0;
        rst_n      = 1'b0;
        ex_in      = '0;
        exp_push   = 1'b0;
        fwd_check  = 1'b0;
        exp_commit = '0;
        exp_fwd    = '0;
        n_cases    = 0;
        errors     = 0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // quiet pipe after reset, checker flags any commit
        fail_before = fail_count;
        repeat (6) @(posedge clk);
        if (fail_count == fail_before) begin
            $display("reset idle check: ok");
        end else begin
            $display("reset idle check: failed");
        end
        fd = $fopen("sim/mem_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/mem_cases.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            c_op, c_f3, c_mrd, c_mwr, c_sel, c_ldrf, c_pc, c_alu, c_mar,
                            c_sdata, c_cmp, c_uimm, c_rd, x_we, x_data, x_addr,
                            x_rmask, x_wmask, x_wdata);
                if (n == 19) begin
                    // memory ops get random gaps, the rest go back to back
                    if (c_op == rv32i_types_pkg::op_load || c_op == rv32i_types_pkg::op_store) begin
                        gap = int'($urandom % 3);
                    end else begin
                        gap = 0;
                    end
                    repeat (gap) idle_cycle();
                    drive_case();
                    n_cases++;
                end else if (line.len() > 1 && line.getc(0) != "#") begin
                    $display("unreadable line in case file: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end
        idle_cycle();
        // drain, bounded
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (pending != 0 && waited < 40);
        if (pending != 0) begin
            $display("timed out with %0d commits still pending", pending);
            errors++;
        end
        $display("cases %0d, passed %0d, failed %0d, other errors %0d",
                 n_cases, pass_count, fail_count, errors);
        if (errors == 0 && fail_count == 0 && n_cases > 0 && pass_count == n_cases) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/mem_checker.sv ====
`default_nettype none

module mem_checker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  pipe_stage_pkg::commit_t    commit,
    input  rv32i_types_pkg::rv32i_word fwd_data,
    input  logic                       exp_push,
    input  pipe_stage_pkg::commit_t    exp_commit,
    input  logic                       fwd_check,
    input  rv32i_types_pkg::rv32i_word exp_fwd,
    output int                         pass_count,
    output int                         fail_count,
    output int                         pending
);

    // expected commits in drive order, with drive cycle and case number
    pipe_stage_pkg::commit_t    exp_q [$];
    int                         drive_q [$];
    int                         id_q [$];
    // fwd_data result per case, folded into its case line
    bit                         fwd_bad [int];
    int                         cyc;
    int                         next_id;
    logic                       fwd_pend;
    rv32i_types_pkg::rv32i_word fwd_exp_d;
    int                         fwd_id;

    function automatic bit check_field(input string name, input int id,
                                       input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s case %0d: got %h expected %h", name, id, got, exp);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // sampled mid-cycle, away from the edge that moves the pipe
    always @(negedge clk) begin : watch
        pipe_stage_pkg::commit_t e;
        int                      id;
        int                      drive_cyc;
        bit                      ok;
        if (!rst_n) begin
            cyc        = 0;
            next_id    = 1;
            fwd_pend   = 1'b0;
            pass_count = 0;
            fail_count = 0;
            exp_q.delete();
            drive_q.delete();
            id_q.delete();
        end else begin
            cyc++;
            // item driven last cycle is in MEM now
            if (fwd_pend) begin
                fwd_bad[fwd_id] = !check_field("fwd_data", fwd_id, fwd_data, fwd_exp_d);
            end
            fwd_pend  = exp_push && fwd_check;
            fwd_exp_d = exp_fwd;
            fwd_id    = next_id;
            if (commit.valid !== 1'b0) begin
                if (exp_q.size() == 0) begin
                    $display("commit seen at cycle %0d while no case was pending", cyc);
                    fail_count++;
                end else begin
                    e         = exp_q.pop_front();
                    id        = id_q.pop_front();
                    drive_cyc = drive_q.pop_front();
                    ok        = 1'b1;
                    ok &= check_field("commit.we", id, 32'(commit.we), 32'(e.we));
                    ok &= check_field("commit.rd", id, 32'(commit.rd), 32'(e.rd));
                    ok &= check_field("commit.rd_data", id, commit.rd_data, e.rd_data);
                    ok &= check_field("commit.mem_addr", id, commit.mem_addr, e.mem_addr);
                    ok &= check_field("commit.mem_rmask", id, 32'(commit.mem_rmask),
                                      32'(e.mem_rmask));
                    ok &= check_field("commit.mem_wmask", id, 32'(commit.mem_wmask),
                                      32'(e.mem_wmask));
                    ok &= check_field("commit.mem_wdata", id, commit.mem_wdata, e.mem_wdata);
                    // two cycles from drive to commit, gaps or not
                    if (cyc != drive_cyc + 2) begin
                        $display("case %0d committed %0d cycles after its drive instead of 2",
                                 id, cyc - drive_cyc);
                        ok = 1'b0;
                    end
                    if (fwd_bad.exists(id) && fwd_bad[id]) begin
                        ok = 1'b0;
                    end
                    if (ok) begin
                        pass_count++;
                        $display("case %0d ok", id);
                    end else begin
                        fail_count++;
                        $display("case %0d failed", id);
                    end
                end
            end else if (exp_q.size() != 0 && (cyc - drive_q[0]) > 20) begin
                $display("case %0d never committed within 20 cycles", id_q[0]);
                void'(exp_q.pop_front());
                void'(drive_q.pop_front());
                void'(id_q.pop_front());
                fail_count++;
            end
            if (exp_push) begin
                exp_q.push_back(exp_commit);
                drive_q.push_back(cyc);
                id_q.push_back(next_id);
                fwd_bad[next_id] = 1'b0;
                next_id++;
            end
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

// ==== hw/mem_wb_top.sv ====
`default_nettype none

module mem_wb_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  pipe_stage_pkg::ex_mem_stage_t ex_in,
    output rv32i_types_pkg::rv32i_word    fwd_data,
    output pipe_stage_pkg::commit_t       commit
);

    pipe_stage_pkg::ex_mem_stage_t ex_mem;
    pipe_stage_pkg::mem_wb_stage_t mem_out;
    rv32i_types_pkg::rv32i_word    dmem_address;
    rv32i_types_pkg::rv32i_word    dmem_wdata;
    rv32i_types_pkg::rv32i_word    dmem_rdata;
    rv32i_types_pkg::byte_mask_t   dmem_byte_enable;
    logic                          dmem_read;
    logic                          dmem_write;
    logic                          dmem_resp;

    // EX/MEM
    ex_mem_reg ex_mem_reg_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_in  (ex_in),
        .ex_mem (ex_mem)
    );

    // MEM, fully combinational
    mem_stage mem_stage_i (
        .mem_in           (ex_mem),
        .dmem_rdata       (dmem_rdata),
        .dmem_resp        (dmem_resp),
        .fwd_data         (fwd_data),
        .mem_out          (mem_out),
        .dmem_address     (dmem_address),
        .dmem_wdata       (dmem_wdata),
        .dmem_byte_enable (dmem_byte_enable),
        .dmem_read        (dmem_read),
        .dmem_write       (dmem_write)
    );

    dmem_sram dmem_sram_i (
        .clk              (clk),
        .dmem_address     (dmem_address),
        .dmem_wdata       (dmem_wdata),
        .dmem_byte_enable (dmem_byte_enable),
        .dmem_read        (dmem_read),
        .dmem_write       (dmem_write),
        .dmem_rdata       (dmem_rdata),
        .dmem_resp        (dmem_resp)
    );

    // MEM/WB and commit
    wb_stage wb_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_out (mem_out),
        .commit  (commit)
    );

endmodule

`default_nettype wire

// ==== hw/wb_stage.sv ====
`default_nettype none

module wb_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  pipe_stage_pkg::mem_wb_stage_t mem_out,
    output pipe_stage_pkg::commit_t       commit
);

    pipe_stage_pkg::mem_wb_stage_t mem_wb;
    rv32i_types_pkg::rv32i_word    lane_data;
    rv32i_types_pkg::rv32i_word    load_data;
    rv32i_types_pkg::rv32i_word    rf_data;
    rv32i_types_pkg::load_funct3_t load_funct3;
    logic                          is_load;

    // MEM/WB register, valid cleared under reset
    always_ff @(posedge clk) begin
        mem_wb <= mem_out;
        if (!rst_n) begin
            mem_wb.ctrl_wd.valid <= 1'b0;
        end
    end

    assign load_funct3 = rv32i_types_pkg::load_funct3_t'(mem_wb.ctrl_wd.funct3);
    assign is_load     = mem_wb.ctrl_wd.opcode == rv32i_types_pkg::op_load;

    // addressed byte or half down to bit 0
    assign lane_data = mem_wb.mdr >> {mem_wb.shift, 3'b000};

    always_comb begin
        case (load_funct3)
            rv32i_types_pkg::lb:  load_data = rv32i_types_pkg::rv32i_word'(signed'(lane_data[7:0]));
            rv32i_types_pkg::lbu: load_data = rv32i_types_pkg::rv32i_word'(lane_data[7:0]);
            rv32i_types_pkg::lh:  load_data = rv32i_types_pkg::rv32i_word'(signed'(lane_data[15:0]));
            rv32i_types_pkg::lhu: load_data = rv32i_types_pkg::rv32i_word'(lane_data[15:0]);
            // lw, whole word as read
            default:              load_data = mem_wb.mdr;
        endcase
    end

    // regfile value
    assign rf_data = is_load ? load_data : mem_wb.rd_data;

    always_comb begin
        commit.valid     = mem_wb.ctrl_wd.valid;
        // x0 never written
        commit.we        = mem_wb.ctrl_wd.valid && mem_wb.ctrl_wd.load_regfile
                           && (mem_wb.rd != 5'd0);
        commit.rd        = mem_wb.rd;
        commit.rd_data   = rf_data;
        commit.mem_addr  = mem_wb.mem_addr;
        commit.mem_rmask = mem_wb.rmask;
        commit.mem_wmask = mem_wb.wmask;
        commit.mem_wdata = mem_wb.wdata;
    end

    // mdr feeds loads only
    // a memory read on any other item would be dropped
    a_read_is_load: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_wb.ctrl_wd.valid && mem_wb.ctrl_wd.mem_read) |-> is_load)
        else $error("wb_stage: memory read on a non-load, pc %h", mem_wb.ctrl_wd.pc);

endmodule

`default_nettype wire

// ==== hw/dmem_sram.sv ====
`default_nettype none
`include "rv32i_mem_defs.svh"

module dmem_sram #(
    parameter int ADDR_BITS = `DMEM_ADDR_BITS
) (
    input  logic                        clk,
    input  rv32i_types_pkg::rv32i_word  dmem_address,
    input  rv32i_types_pkg::rv32i_word  dmem_wdata,
    input  rv32i_types_pkg::byte_mask_t dmem_byte_enable,
    input  logic                        dmem_read,
    input  logic                        dmem_write,
    output rv32i_types_pkg::rv32i_word  dmem_rdata,
    output logic                        dmem_resp
);

    localparam int DEPTH = 1 << ADDR_BITS;
    localparam int LANES = $bits(rv32i_types_pkg::byte_mask_t);

    rv32i_types_pkg::rv32i_word mem [DEPTH];
    logic [ADDR_BITS-1:0]       word_idx;

    // word index, byte offset dropped, upper bits wrap
    assign word_idx = dmem_address[ADDR_BITS+1:2];

    // contents start cleared
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // write lands at the edge, only enabled lanes change
    always @(posedge clk) begin
        if (dmem_write) begin
            for (int b = 0; b < LANES; b++) begin
                if (dmem_byte_enable[b]) begin
                    mem[word_idx][8*b +: 8] <= dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    // same-cycle read, zero when idle
    assign dmem_rdata = dmem_read ? mem[word_idx] : '0;
    // always answers at once
    assign dmem_resp  = dmem_read || dmem_write;

endmodule

`default_nettype wire

// ==== hw/mem_stage.sv ====
`default_nettype none

module mem_stage (
    input  pipe_stage_pkg::ex_mem_stage_t mem_in,
    input  rv32i_types_pkg::rv32i_word    dmem_rdata,
    input  logic                          dmem_resp,
    output rv32i_types_pkg::rv32i_word    fwd_data,
    output pipe_stage_pkg::mem_wb_stage_t mem_out,
    output rv32i_types_pkg::rv32i_word    dmem_address,
    output rv32i_types_pkg::rv32i_word    dmem_wdata,
    output rv32i_types_pkg::byte_mask_t   dmem_byte_enable,
    output logic                          dmem_read,
    output logic                          dmem_write
);

    logic [1:0]                     shift;
    logic [1:0]                     size;
    logic                           is_load;
    logic                           is_store;
    logic                           misaligned;
    rv32i_types_pkg::byte_mask_t    lane_byte;
    rv32i_types_pkg::byte_mask_t    lane_half;
    rv32i_types_pkg::byte_mask_t    lane_word;
    rv32i_types_pkg::byte_mask_t    wmask;
    rv32i_types_pkg::byte_mask_t    rmask;
    rv32i_types_pkg::load_funct3_t  load_funct3;
    rv32i_types_pkg::store_funct3_t store_funct3;

    assign shift        = mem_in.mar[1:0];
    assign size         = mem_in.ctrl_wd.funct3[1:0];
    assign load_funct3  = rv32i_types_pkg::load_funct3_t'(mem_in.ctrl_wd.funct3);
    assign store_funct3 = rv32i_types_pkg::store_funct3_t'(mem_in.ctrl_wd.funct3);

    assign is_load  = mem_in.ctrl_wd.valid && (mem_in.ctrl_wd.opcode == rv32i_types_pkg::op_load);
    assign is_store = mem_in.ctrl_wd.valid && (mem_in.ctrl_wd.opcode == rv32i_types_pkg::op_store);

    // lane rule, shared by loads and stores
    // byte: one-hot at the offset
    assign lane_byte = 4'b0001 << shift;
    // halfword: lanes 1:0 or 3:2, nothing on an odd offset
    assign lane_half = shift[0] ? 4'b0000 : (4'b0011 << shift);
    // word: only at offset 0
    assign lane_word = (shift == 2'b00) ? 4'b1111 : 4'b0000;

    always_comb begin
        wmask = '0;
        if (is_store) begin
            case (store_funct3)
                rv32i_types_pkg::sb: wmask = lane_byte;
                rv32i_types_pkg::sh: wmask = lane_half;
                rv32i_types_pkg::sw: wmask = lane_word;
                default:             wmask = '0;
            endcase
        end
    end

    always_comb begin
        rmask = '0;
        if (is_load) begin
            case (load_funct3)
                rv32i_types_pkg::lb, rv32i_types_pkg::lbu: rmask = lane_byte;
                rv32i_types_pkg::lh, rv32i_types_pkg::lhu: rmask = lane_half;
                rv32i_types_pkg::lw:                       rmask = lane_word;
                default:                                   rmask = '0;
            endcase
        end
    end

    // memory side, word aligned
    assign dmem_address     = {mem_in.mar[31:2], 2'b00};
    // store data moves up to its lane
    assign dmem_wdata       = mem_in.mem_data_out << {shift, 3'b000};
    assign dmem_byte_enable = wmask;
    // bubbles never touch memory
    assign dmem_read        = mem_in.ctrl_wd.valid && mem_in.ctrl_wd.mem_read;
    assign dmem_write       = mem_in.ctrl_wd.valid && mem_in.ctrl_wd.mem_write;

    // forwarding value for the non-load sources
    always_comb begin
        case (mem_in.ctrl_wd.regfilemux_sel)
            rv32i_types_pkg::rf_alu_out:  fwd_data = mem_in.alu_out;
            rv32i_types_pkg::rf_br_en:    fwd_data = rv32i_types_pkg::rv32i_word'(mem_in.cmp_out);
            rv32i_types_pkg::rf_u_imm:    fwd_data = mem_in.u_imm;
            rv32i_types_pkg::rf_pc_plus4: fwd_data = mem_in.ctrl_wd.pc + 32'd4;
            // load data is not ready until WB
            default:                      fwd_data = mem_in.alu_out;
        endcase
    end

    // MEM/WB payload
    always_comb begin
        mem_out.ctrl_wd  = mem_in.ctrl_wd;
        mem_out.rd_data  = fwd_data;
        // mdr only takes data the memory has answered with
        mem_out.mdr      = dmem_resp ? dmem_rdata : '0;
        mem_out.shift    = shift;
        mem_out.rd       = mem_in.rd;
        mem_out.mem_addr = dmem_address;
        mem_out.rmask    = rmask;
        mem_out.wmask    = wmask;
        mem_out.wdata    = dmem_write ? dmem_wdata : '0;
    end

    // halfword on odd offset, word on any nonzero offset
    assign misaligned = (is_load || is_store)
                        && (((size == 2'b01) && shift[0]) || ((size == 2'b10) && (shift != 2'b00)));

    always_comb begin
        a_aligned: assert (misaligned !== 1'b1)
            else $error("mem_stage: misaligned access, addr %h funct3 %b",
                        mem_in.mar, mem_in.ctrl_wd.funct3);
    end

endmodule

`default_nettype wire

// ==== hw/ex_mem_reg.sv ====
`default_nettype none

module ex_mem_reg (
    input  logic                          clk,
    input  logic                          rst_n,
    input  pipe_stage_pkg::ex_mem_stage_t ex_in,
    output pipe_stage_pkg::ex_mem_stage_t ex_mem
);

    // payload loads every edge, no stall in this pipe
    // only valid is forced low under reset
    always_ff @(posedge clk) begin
        ex_mem <= ex_in;
        if (!rst_n) begin
            ex_mem.ctrl_wd.valid <= 1'b0;
        end
    end

    // decode never asks for a read and a write on one item
    // checked on the registered copy the memory stage acts on
    property p_single_mem_op;
        @(posedge clk) disable iff (!rst_n)
        ex_mem.ctrl_wd.valid |-> !(ex_mem.ctrl_wd.mem_read && ex_mem.ctrl_wd.mem_write);
    endproperty

    a_single_mem_op: assert property (p_single_mem_op)
        else $error("ex_mem_reg: read and write set together, pc %h", ex_mem.ctrl_wd.pc);

endmodule

`default_nettype wire

// ==== hw/pipe_stage_pkg.sv ====
`default_nettype none

package pipe_stage_pkg;

    // control word, travels with the item down the pipe
    typedef struct packed {
        logic                             valid;
        rv32i_types_pkg::opcode_t         opcode;
        logic [2:0]                       funct3;
        logic                             mem_read;
        logic                             mem_write;
        rv32i_types_pkg::regfilemux_sel_t regfilemux_sel;
        logic                             load_regfile;
        rv32i_types_pkg::rv32i_word       pc;
    } ctrl_word_t;

    // EX/MEM payload
    typedef struct packed {
        ctrl_word_t                 ctrl_wd;
        rv32i_types_pkg::rv32i_word alu_out;
        rv32i_types_pkg::rv32i_word mar;
        // store data, still in the low lanes
        rv32i_types_pkg::rv32i_word mem_data_out;
        logic                       cmp_out;
        rv32i_types_pkg::rv32i_word u_imm;
        rv32i_types_pkg::reg_idx_t  rd;
    } ex_mem_stage_t;

    // MEM/WB payload
    typedef struct packed {
        ctrl_word_t                  ctrl_wd;
        // value for anything that is not a load
        rv32i_types_pkg::rv32i_word  rd_data;
        rv32i_types_pkg::rv32i_word  mdr;
        // byte offset of the access
        logic [1:0]                  shift;
        rv32i_types_pkg::reg_idx_t   rd;
        rv32i_types_pkg::rv32i_word  mem_addr;
        rv32i_types_pkg::byte_mask_t rmask;
        rv32i_types_pkg::byte_mask_t wmask;
        rv32i_types_pkg::rv32i_word  wdata;
    } mem_wb_stage_t;

    // one record per retired item
    typedef struct packed {
        logic                        valid;
        logic                        we;
        rv32i_types_pkg::reg_idx_t   rd;
        rv32i_types_pkg::rv32i_word  rd_data;
        rv32i_types_pkg::rv32i_word  mem_addr;
        rv32i_types_pkg::byte_mask_t mem_rmask;
        rv32i_types_pkg::byte_mask_t mem_wmask;
        rv32i_types_pkg::rv32i_word  mem_wdata;
    } commit_t;

endpackage

`default_nettype wire

// ==== hw/rv32i_types_pkg.sv ====
`default_nettype none
`include "rv32i_mem_defs.svh"

package rv32i_types_pkg;

    // one machine word, data or address
    typedef logic [`RV32_XLEN-1:0] rv32i_word;
    // one bit per byte lane, bit 0 is the lowest byte
    typedef logic [3:0] byte_mask_t;
    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // major opcodes as seen at this end of the pipe
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_jal   = 7'b1101111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // low two bits give the access size, bit 2 means unsigned
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // regfile source select, rf_ prefix keeps lw apart from the funct3 code
    typedef enum logic [2:0] {
        rf_alu_out  = 3'b000,
        rf_br_en    = 3'b001,
        rf_u_imm    = 3'b010,
        rf_lw       = 3'b011,
        rf_pc_plus4 = 3'b100,
        rf_load     = 3'b101
    } regfilemux_sel_t;

endpackage

`default_nettype wire

// ==== hw/rv32i_mem_defs.svh ====
`ifndef RV32I_MEM_DEFS_SVH
`define RV32I_MEM_DEFS_SVH

// width of one machine word
// shared by data, addresses and the pc
`define RV32_XLEN 32

// word-address bits of the data memory
// 8 bits give 256 words, 1 KiB
// the byte offset sits below these bits
`define DMEM_ADDR_BITS 8

`endif
